// File: design/dm_split_pkg.sv
package dm_split_pkg;

    // ====================
    // field widths
    // ====================

    // byte address of a request and of each chunk cut from it
    localparam int ADDR_W = 32;

    // byte length field, wide enough to hold a full 4 KB request (4096)
    localparam int LEN_W = 13;

    // the completion data word rides along with the header and is never altered
    localparam int DATA_W = 32;

    // ====================
    // request opcodes
    // ====================

    // only DM reads and writes reach the splitter
    // write payload beats are not modelled, so a write is a single header here
    typedef enum logic [0:0] {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } req_op_e;

endpackage

// File: design/dm_meta_ram.sv
`timescale 1ns/10ps

module dm_meta_ram #(
    parameter int NUM_TAGS = 256
) (
    input  logic                        clk,
    input  logic                        i_we,
    input  logic [$clog2(NUM_TAGS)-1:0] i_wtag,
    input  logic                        i_wbit,
    input  logic [$clog2(NUM_TAGS)-1:0] i_rtag,
    output logic                        o_rbit
);

    // one entry per tag holding the metadata bit the AFU sent with a read
    // the chunker overwrites that bit on the wire, so this is the only copy
    logic mem [NUM_TAGS];

    // written on the edge a read is accepted by decode
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_wtag] <= i_wbit;
        end
    end

    // read side is combinational so the fixup stage can use it in the
    // same cycle the completion header is presented
    assign o_rbit = mem[i_rtag];

endmodule

// File: design/dm_req_decode.sv
`timescale 1ns/10ps

module dm_req_decode #(
    parameter int NUM_TAGS = 256
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             i_req_valid,
    output logic                             o_req_ready,
    input  dm_split_pkg::req_op_e            i_req_op,
    input  logic [dm_split_pkg::ADDR_W-1:0]  i_req_addr,
    input  logic [dm_split_pkg::LEN_W-1:0]   i_req_len,
    input  logic [$clog2(NUM_TAGS)-1:0]      i_req_tag,
    input  logic                             i_req_meta,
    output logic                             o_dec_valid,
    input  logic                             i_dec_ready,
    output dm_split_pkg::req_op_e            o_dec_op,
    output logic [dm_split_pkg::ADDR_W-1:0]  o_dec_addr,
    output logic [dm_split_pkg::LEN_W-1:0]   o_dec_len,
    output logic [$clog2(NUM_TAGS)-1:0]      o_dec_tag,
    output logic                             o_dec_meta,
    output logic                             o_ram_we,
    output logic [$clog2(NUM_TAGS)-1:0]      o_ram_tag,
    output logic                             o_ram_bit
);
    import dm_split_pkg::*;

    logic dec_full;
    logic req_accept;

    // the holding register takes a new request when it is empty, or when
    // the chunker pulls the current one out on this same edge
    assign o_req_ready = !dec_full || i_dec_ready;
    assign req_accept  = i_req_valid && o_req_ready;
    assign o_dec_valid = dec_full;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_full <= 1'b0;
        end else if (req_accept) begin
            dec_full <= 1'b1;
        end else if (i_dec_ready) begin
            dec_full <= 1'b0;
        end
    end

    // request fields, loaded on acceptance and seen by the chunker next cycle
    always_ff @(posedge clk) begin
        if (req_accept) begin
            o_dec_op   <= i_req_op;
            o_dec_addr <= i_req_addr;
            o_dec_len  <= i_req_len;
            o_dec_tag  <= i_req_tag;
            o_dec_meta <= i_req_meta;
        end
    end

    // reads get their original metadata bit parked in the tag RAM
    // this lands two edges before the first chunk can leave the chunker,
    // so any completion for the tag finds the entry already written
    assign o_ram_we  = req_accept && (i_req_op == OP_READ);
    assign o_ram_tag = i_req_tag;
    assign o_ram_bit = i_req_meta;

    // a zero length request would reach the chunker as an empty chunk
    a_req_len_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        req_accept |-> (i_req_len != '0));

endmodule

// File: design/dm_req_chunker.sv
`timescale 1ns/10ps

module dm_req_chunker #(
    parameter int REQ_MAX_BYTES = 256,
    parameter int NUM_TAGS      = 256
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             i_dec_valid,
    output logic                             o_dec_ready,
    input  dm_split_pkg::req_op_e            i_dec_op,
    input  logic [dm_split_pkg::ADDR_W-1:0]  i_dec_addr,
    input  logic [dm_split_pkg::LEN_W-1:0]   i_dec_len,
    input  logic [$clog2(NUM_TAGS)-1:0]      i_dec_tag,
    input  logic                             i_dec_meta,
    output logic                             o_tx_valid,
    input  logic                             i_tx_ready,
    output dm_split_pkg::req_op_e            o_tx_op,
    output logic [dm_split_pkg::ADDR_W-1:0]  o_tx_addr,
    output logic [dm_split_pkg::LEN_W-1:0]   o_tx_len,
    output logic [$clog2(NUM_TAGS)-1:0]      o_tx_tag,
    output logic                             o_tx_meta,
    output logic                             o_tx_no_commit,
    output logic                             o_tx_last
);
    import dm_split_pkg::*;

    localparam int OFF_W = $clog2(REQ_MAX_BYTES);
    localparam int TAG_W = $clog2(NUM_TAGS);

    typedef enum logic {
        CH_IDLE,
        CH_SPLIT
    } ch_state_e;

    ch_state_e         state;
    req_op_e           cur_op;
    logic [ADDR_W-1:0] cur_addr;
    logic [LEN_W-1:0]  rem_len;
    logic [TAG_W-1:0]  cur_tag;
    logic              cur_meta;
    logic [LEN_W-1:0]  to_boundary;
    logic [LEN_W-1:0]  chunk_len;
    logic              chunk_last;
    logic              dec_accept;
    logic              tx_fire;

    // ====================
    // chunk geometry
    // ====================

    // bytes left before the next REQ_MAX_BYTES aligned address
    // after the first chunk the address is aligned and this is a full chunk
    assign to_boundary = LEN_W'(REQ_MAX_BYTES) - LEN_W'(cur_addr[OFF_W-1:0]);
    assign chunk_last  = (rem_len <= to_boundary);
    assign chunk_len   = chunk_last ? rem_len : to_boundary;

    // the next request is taken while idle, or on the edge the final chunk leaves
    assign tx_fire     = o_tx_valid && i_tx_ready;
    assign o_dec_ready = (state == CH_IDLE) || (tx_fire && chunk_last);
    assign dec_accept  = i_dec_valid && o_dec_ready;

    // ====================
    // state and progress
    // ====================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= CH_IDLE;
        end else if (dec_accept) begin
            state <= CH_SPLIT;
        end else if (tx_fire && chunk_last) begin
            state <= CH_IDLE;
        end
    end

    // address walks forward and the remainder shrinks by each chunk sent
    always_ff @(posedge clk) begin
        if (dec_accept) begin
            cur_op   <= i_dec_op;
            cur_addr <= i_dec_addr;
            rem_len  <= i_dec_len;
            cur_tag  <= i_dec_tag;
            cur_meta <= i_dec_meta;
        end else if (tx_fire) begin
            cur_addr <= cur_addr + ADDR_W'(chunk_len);
            rem_len  <= rem_len - chunk_len;
        end
    end

    // ====================
    // outgoing chunk
    // ====================

    assign o_tx_valid = (state == CH_SPLIT);
    assign o_tx_op    = cur_op;
    assign o_tx_addr  = cur_addr;
    assign o_tx_len   = chunk_len;
    assign o_tx_tag   = cur_tag;
    assign o_tx_last  = chunk_last;

    // reads mark only the last chunk so its completion is the one that keeps FC
    // writes leave metadata alone and hold off the commit until the end
    assign o_tx_meta      = (cur_op == OP_READ) ? chunk_last : cur_meta;
    assign o_tx_no_commit = (cur_op == OP_WRITE) && !chunk_last;

    a_no_boundary_cross: assert property (@(posedge clk) disable iff (!rst_n)
        o_tx_valid |-> (((o_tx_addr + ADDR_W'(o_tx_len) - ADDR_W'(1)) >> OFF_W)
                        == (o_tx_addr >> OFF_W)));

    a_chunk_len_range: assert property (@(posedge clk) disable iff (!rst_n)
        o_tx_valid |-> ((o_tx_len != '0) && (o_tx_len <= LEN_W'(REQ_MAX_BYTES))));

    // a held chunk must not change under back-pressure
    a_tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (o_tx_valid && !i_tx_ready) |=> (o_tx_valid && $stable(o_tx_addr)
            && $stable(o_tx_len) && $stable(o_tx_tag) && $stable(o_tx_op)
            && $stable(o_tx_meta) && $stable(o_tx_last) && $stable(o_tx_no_commit)));

endmodule

// File: design/dm_cpl_fixup.sv
`timescale 1ns/10ps

module dm_cpl_fixup #(
    parameter int NUM_TAGS = 256
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             i_cpl_valid,
    output logic                             o_cpl_ready,
    input  logic                             i_cpl_dm,
    input  logic [$clog2(NUM_TAGS)-1:0]      i_cpl_tag,
    input  logic                             i_cpl_meta,
    input  logic                             i_cpl_fc,
    input  logic [dm_split_pkg::DATA_W-1:0]  i_cpl_data,
    output logic [$clog2(NUM_TAGS)-1:0]      o_rtag,
    input  logic                             i_rbit,
    output logic                             o_rx_valid,
    input  logic                             i_rx_ready,
    output logic [$clog2(NUM_TAGS)-1:0]      o_rx_tag,
    output logic                             o_rx_meta,
    output logic                             o_rx_fc,
    output logic [dm_split_pkg::DATA_W-1:0]  o_rx_data
);

    logic cpl_accept;

    // a single output register, refilled on the edge it drains
    assign o_cpl_ready = !o_rx_valid || i_rx_ready;
    assign cpl_accept  = i_cpl_valid && o_cpl_ready;

    // look up the original metadata of the incoming completion's tag
    assign o_rtag = i_cpl_tag;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_rx_valid <= 1'b0;
        end else if (cpl_accept) begin
            o_rx_valid <= 1'b1;
        end else if (i_rx_ready) begin
            o_rx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cpl_accept) begin
            o_rx_tag  <= i_cpl_tag;
            o_rx_data <= i_cpl_data;
            if (i_cpl_dm) begin
                // the echoed bit is set only for the final chunk of a read,
                // so FC survives on that completion alone
                o_rx_fc   <= i_cpl_fc && i_cpl_meta;
                o_rx_meta <= i_rbit;
            end else begin
                // Non-DM traffic is not touched
                o_rx_fc   <= i_cpl_fc;
                o_rx_meta <= i_cpl_meta;
            end
        end
    end

endmodule

// File: design/dm_req_splitter_top.sv
`timescale 1ns/10ps

module dm_req_splitter_top #(
    parameter int REQ_MAX_BYTES = 256,
    parameter int NUM_TAGS      = 256
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             i_req_valid,
    output logic                             o_req_ready,
    input  dm_split_pkg::req_op_e            i_req_op,
    input  logic [dm_split_pkg::ADDR_W-1:0]  i_req_addr,
    input  logic [dm_split_pkg::LEN_W-1:0]   i_req_len,
    input  logic [$clog2(NUM_TAGS)-1:0]      i_req_tag,
    input  logic                             i_req_meta,
    output logic                             o_tx_valid,
    input  logic                             i_tx_ready,
    output dm_split_pkg::req_op_e            o_tx_op,
    output logic [dm_split_pkg::ADDR_W-1:0]  o_tx_addr,
    output logic [dm_split_pkg::LEN_W-1:0]   o_tx_len,
    output logic [$clog2(NUM_TAGS)-1:0]      o_tx_tag,
    output logic                             o_tx_meta,
    output logic                             o_tx_no_commit,
    output logic                             o_tx_last,
    input  logic                             i_cpl_valid,
    output logic                             o_cpl_ready,
    input  logic                             i_cpl_dm,
    input  logic [$clog2(NUM_TAGS)-1:0]      i_cpl_tag,
    input  logic                             i_cpl_meta,
    input  logic                             i_cpl_fc,
    input  logic [dm_split_pkg::DATA_W-1:0]  i_cpl_data,
    output logic                             o_rx_valid,
    input  logic                             i_rx_ready,
    output logic [$clog2(NUM_TAGS)-1:0]      o_rx_tag,
    output logic                             o_rx_meta,
    output logic                             o_rx_fc,
    output logic [dm_split_pkg::DATA_W-1:0]  o_rx_data
);
    import dm_split_pkg::*;

    localparam int TAG_W = $clog2(NUM_TAGS);

    // ====================
    // decode to chunker
    // ====================

    logic              dec_valid;
    logic              dec_ready;
    req_op_e           dec_op;
    logic [ADDR_W-1:0] dec_addr;
    logic [LEN_W-1:0]  dec_len;
    logic [TAG_W-1:0]  dec_tag;
    logic              dec_meta;

    // tag RAM write side from decode, read side from fixup
    logic              ram_we;
    logic [TAG_W-1:0]  ram_wtag;
    logic              ram_wbit;
    logic [TAG_W-1:0]  ram_rtag;
    logic              ram_rbit;

    dm_req_decode #(.NUM_TAGS(NUM_TAGS)) decode_inst (
        .clk, .rst_n,
        .i_req_valid, .o_req_ready, .i_req_op, .i_req_addr, .i_req_len,
        .i_req_tag, .i_req_meta,
        .o_dec_valid(dec_valid), .i_dec_ready(dec_ready), .o_dec_op(dec_op),
        .o_dec_addr(dec_addr), .o_dec_len(dec_len), .o_dec_tag(dec_tag),
        .o_dec_meta(dec_meta),
        .o_ram_we(ram_we), .o_ram_tag(ram_wtag), .o_ram_bit(ram_wbit)
    );

    dm_meta_ram #(.NUM_TAGS(NUM_TAGS)) meta_ram_inst (
        .clk,
        .i_we(ram_we), .i_wtag(ram_wtag), .i_wbit(ram_wbit),
        .i_rtag(ram_rtag), .o_rbit(ram_rbit)
    );

    dm_req_chunker #(.REQ_MAX_BYTES(REQ_MAX_BYTES), .NUM_TAGS(NUM_TAGS)) chunker_inst (
        .clk, .rst_n,
        .i_dec_valid(dec_valid), .o_dec_ready(dec_ready), .i_dec_op(dec_op),
        .i_dec_addr(dec_addr), .i_dec_len(dec_len), .i_dec_tag(dec_tag),
        .i_dec_meta(dec_meta),
        .o_tx_valid, .i_tx_ready, .o_tx_op, .o_tx_addr, .o_tx_len, .o_tx_tag,
        .o_tx_meta, .o_tx_no_commit, .o_tx_last
    );

    // completions return on the FIM side and leave toward the AFU repaired
    dm_cpl_fixup #(.NUM_TAGS(NUM_TAGS)) fixup_inst (
        .clk, .rst_n,
        .i_cpl_valid, .o_cpl_ready, .i_cpl_dm, .i_cpl_tag, .i_cpl_meta,
        .i_cpl_fc, .i_cpl_data,
        .o_rtag(ram_rtag), .i_rbit(ram_rbit),
        .o_rx_valid, .i_rx_ready, .o_rx_tag, .o_rx_meta, .o_rx_fc, .o_rx_data
    );

endmodule

// File: tb/dm_split_checker.sv
`timescale 1ns/10ps

module dm_split_checker #(
    parameter int REQ_MAX_BYTES = 256,
    parameter int NUM_TAGS      = 256
) (
    input  logic                            clk, rst_n,
    input  logic                            i_req_valid, o_req_ready, i_req_meta,
    input  dm_split_pkg::req_op_e           i_req_op, o_tx_op,
    input  logic [dm_split_pkg::ADDR_W-1:0] i_req_addr, o_tx_addr,
    input  logic [dm_split_pkg::LEN_W-1:0]  i_req_len, o_tx_len,
    input  logic [$clog2(NUM_TAGS)-1:0]     i_req_tag, o_tx_tag, i_cpl_tag, o_rx_tag,
    input  logic                            o_tx_valid, i_tx_ready, o_tx_meta,
    input  logic                            o_tx_no_commit, o_tx_last,
    input  logic                            i_cpl_valid, o_cpl_ready, i_cpl_dm,
    input  logic                            i_cpl_meta, i_cpl_fc,
    input  logic [dm_split_pkg::DATA_W-1:0] i_cpl_data, o_rx_data,
    input  logic                            o_rx_valid, i_rx_ready, o_rx_meta, o_rx_fc,
    output int                              o_pending
);
    import dm_split_pkg::*;

    localparam int TAG_W = $clog2(NUM_TAGS);

    // one TX chunk, packed in the same order as the DUT fields are compared
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [TAG_W-1:0]  tag;
        req_op_e           op;
        logic              meta;
        logic              no_commit;
        logic              last;
    } chunk_t;

    // one completion as the AFU should see it
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic              meta;
        logic              fc;
        logic [DATA_W-1:0] data;
    } cpl_t;

    // chunks still to leave, read chunks still to be answered, completions still to drain
    chunk_t tx_exp_q [$];
    chunk_t rd_q [$];
    cpl_t   rx_exp_q [$];
    int     chunk_errs, cpl_errs, count_errs;
    int     chunks_modeled, chunks_seen, cpl_in, cpl_out;

    task automatic compare_value(input string test, input logic [63:0] exp,
                                 input logic [63:0] act, inout int errs);
        if (exp !== act) begin
            $display("[ERROR] %s at %0t: expected 0x%0h, actual 0x%0h", test, $time, exp, act);
            errs++;
        end
    endtask

    // ====================
    // reference model
    // ====================

    // handshakes are sampled mid-cycle, where every stream is stable
    always @(negedge clk) begin : model
        chunk_t            c;
        cpl_t              e;
        logic [ADDR_W-1:0] a;
        int                rem;
        int                room;

        if (rst_n && i_req_valid && o_req_ready) begin
            a   = i_req_addr;
            rem = int'(i_req_len);
            // each chunk runs to the next aligned boundary or to the end of the request
            while (rem > 0) begin
                room        = REQ_MAX_BYTES - int'(a % REQ_MAX_BYTES);
                c.last      = (rem <= room);
                c.len       = LEN_W'(c.last ? rem : room);
                c.addr      = a;
                c.tag       = i_req_tag;
                c.op        = i_req_op;
                c.meta      = (i_req_op == OP_READ) ? c.last : i_req_meta;
                c.no_commit = (i_req_op == OP_WRITE) && !c.last;
                tx_exp_q.push_back(c);
                // the completion side must give back the AFU's own metadata bit
                if (i_req_op == OP_READ) begin
                    c.meta = i_req_meta;
                    rd_q.push_back(c);
                end
                chunks_modeled++;
                a   = a + ADDR_W'(c.len);
                rem = rem - int'(c.len);
            end
        end

        // address, length, tag, opcode, meta, no_commit and last all in one compare
        if (rst_n && o_tx_valid && i_tx_ready) begin
            chunks_seen++;
            if (tx_exp_q.size() == 0) begin
                $display("chunk at 0x%0h issued at %0t with no request left to split",
                         o_tx_addr, $time);
                count_errs++;
            end else begin
                compare_value("tx_chunk", tx_exp_q.pop_front(), {o_tx_addr, o_tx_len,
                              o_tx_tag, o_tx_op, o_tx_meta, o_tx_no_commit, o_tx_last},
                              chunk_errs);
            end
        end

        // non-DM completions are expected back untouched
        if (rst_n && i_cpl_valid && o_cpl_ready) begin
            cpl_in++;
            e = {i_cpl_tag, i_cpl_meta, i_cpl_fc, i_cpl_data};
            if (i_cpl_dm && rd_q.size() == 0) begin
                $display("DM completion for tag 0x%0h at %0t answers no read chunk",
                         i_cpl_tag, $time);
                count_errs++;
            end else if (i_cpl_dm) begin
                // FC survives only on the final chunk's completion
                c      = rd_q.pop_front();
                e.meta = c.meta;
                e.fc   = i_cpl_fc && c.last;
            end
            rx_exp_q.push_back(e);
        end

        if (rst_n && o_rx_valid && i_rx_ready) begin
            cpl_out++;
            if (rx_exp_q.size() == 0) begin
                $display("completion for tag 0x%0h delivered at %0t was never sent in",
                         o_rx_tag, $time);
                count_errs++;
            end else begin
                compare_value("rx_completion", rx_exp_q.pop_front(),
                              {o_rx_tag, o_rx_meta, o_rx_fc, o_rx_data}, cpl_errs);
            end
        end
    end

    // work still owed by the DUT, published on the edge so it is stable mid-cycle
    always @(posedge clk) begin
        o_pending <= tx_exp_q.size() + rd_q.size() + rx_exp_q.size();
    end

    // beats lost or duplicated show up as a count mismatch
    task automatic check_counts();
        compare_value("chunk_count", chunks_modeled, chunks_seen, count_errs);
        compare_value("completion_count", cpl_in, cpl_out, count_errs);
    endtask

endmodule

// File: tb/tb_dm_req_splitter.sv
`timescale 1ns/10ps

module tb_dm_req_splitter;
    import dm_split_pkg::*;

    localparam int REQ_MAX_BYTES  = 256;
    localparam int NUM_TAGS       = 256;
    localparam int TAG_W          = $clog2(NUM_TAGS);
    localparam int NUM_REQS       = 150;
    localparam int TIMEOUT_CYCLES = NUM_REQS * 40 + 2000;

    // read chunks wait here for their completions in issue order
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             meta;
        logic             last;
    } rd_chunk_t;

    logic              clk, rst_n;
    logic              i_req_valid, o_req_ready, i_req_meta;
    req_op_e           i_req_op, o_tx_op;
    logic [ADDR_W-1:0] i_req_addr, o_tx_addr;
    logic [LEN_W-1:0]  i_req_len, o_tx_len;
    logic [TAG_W-1:0]  i_req_tag, o_tx_tag, i_cpl_tag, o_rx_tag;
    logic              o_tx_valid, i_tx_ready, o_tx_meta, o_tx_no_commit, o_tx_last;
    logic              i_cpl_valid, o_cpl_ready, i_cpl_dm, i_cpl_meta, i_cpl_fc;
    logic [DATA_W-1:0] i_cpl_data, o_rx_data;
    logic              o_rx_valid, i_rx_ready, o_rx_meta, o_rx_fc;

    integer    seed;
    int        cycles;
    int        chk_pending;
    bit        busy [NUM_TAGS];
    rd_chunk_t pend_q [$];

    dm_req_splitter_top #(
        .REQ_MAX_BYTES(REQ_MAX_BYTES),
        .NUM_TAGS     (NUM_TAGS)
    ) dm_req_splitter_top_inst (.*);

    dm_split_checker #(
        .REQ_MAX_BYTES(REQ_MAX_BYTES),
        .NUM_TAGS     (NUM_TAGS)
    ) chk_inst (
        .*,
        .o_pending(chk_pending)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ====================
    // request stream
    // ====================

    initial begin : main
        logic [TAG_W-1:0]  tag;
        logic [ADDR_W-1:0] addr;
        req_op_e           op;
        int                total;

        seed        = 80;
        rst_n       = 1'b0;
        i_req_valid = 1'b0;
        i_req_op    = OP_READ;
        i_req_addr  = '0;
        i_req_len   = '0;
        i_req_tag   = '0;
        i_req_meta  = 1'b0;
        i_tx_ready  = 1'b0;
        i_rx_ready  = 1'b0;
        i_cpl_valid = 1'b0;
        i_cpl_dm    = 1'b0;
        i_cpl_tag   = '0;
        i_cpl_meta  = 1'b0;
        i_cpl_fc    = 1'b0;
        i_cpl_data  = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        for (int n = 0; n < NUM_REQS; n++) begin
            @(posedge clk);
            // the metadata RAM holds one entry per tag, so reads in flight never share one
            do begin
                tag = TAG_W'({$random(seed)} % NUM_TAGS);
            end while (busy[tag]);
            op = ($random(seed) & 1) ? OP_WRITE : OP_READ;
            if (op == OP_READ) begin
                busy[tag] = 1'b1;
            end
            addr = ADDR_W'({$random(seed)} >> 1);
            // some requests start right on a chunk boundary
            if (({$random(seed)} % 4) == 0) begin
                addr = addr & ~ADDR_W'(REQ_MAX_BYTES - 1);
            end
            i_req_valid <= 1'b1;
            i_req_op    <= op;
            i_req_addr  <= addr;
            i_req_len   <= LEN_W'(1 + {$random(seed)} % 1024);
            i_req_tag   <= tag;
            i_req_meta  <= ($random(seed) & 1) != 0;
            // the beat moves on the next rising edge once ready is seen high
            do begin
                @(negedge clk);
            end while (!o_req_ready);
        end
        @(posedge clk);
        i_req_valid <= 1'b0;

        // let every chunk and completion drain out
        do begin
            @(negedge clk);
        end while (pend_q.size() != 0 || chk_pending != 0 || i_cpl_valid || o_rx_valid);

        chk_inst.check_counts();
        total = chk_inst.chunk_errs + chk_inst.cpl_errs + chk_inst.count_errs;
        $display("errors: chunk %0d, completion %0d, count %0d",
                 chk_inst.chunk_errs, chk_inst.cpl_errs, chk_inst.count_errs);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // ====================
    // completer model
    // ====================

    // every read chunk that leaves gets one DM completion later on
    always @(negedge clk) begin
        if (rst_n && o_tx_valid && i_tx_ready && o_tx_op == OP_READ) begin
            pend_q.push_back({o_tx_tag, o_tx_meta, o_tx_last});
        end
    end

    initial begin : completer
        rd_chunk_t c;
        bit        send;
        bit        final_cpl;

        @(posedge rst_n);
        forever begin
            @(posedge clk);
            i_cpl_valid <= 1'b0;
            send      = 1'b0;
            final_cpl = 1'b0;
            if (pend_q.size() != 0 && ({$random(seed)} % 4) != 0) begin
                c = pend_q.pop_front();
                i_cpl_dm   <= 1'b1;
                i_cpl_tag  <= c.tag;
                i_cpl_meta <= c.meta;
                i_cpl_fc   <= 1'b1;
                send      = 1'b1;
                final_cpl = c.last;
            end else if (({$random(seed)} % 8) == 0) begin
                // unrelated non-DM traffic on the same completion stream
                i_cpl_dm   <= 1'b0;
                i_cpl_tag  <= TAG_W'({$random(seed)} % NUM_TAGS);
                i_cpl_meta <= ($random(seed) & 1) != 0;
                i_cpl_fc   <= ($random(seed) & 1) != 0;
                send = 1'b1;
            end
            if (send) begin
                i_cpl_valid <= 1'b1;
                i_cpl_data  <= $random(seed);
                do begin
                    @(negedge clk);
                end while (!o_cpl_ready);
                // the tag is free again once the DUT takes its final completion
                if (final_cpl) begin
                    busy[c.tag] = 1'b0;
                end
            end
        end
    end

    // back-pressure on both outgoing streams
    always @(posedge clk) begin
        i_tx_ready <= ({$random(seed)} % 4) != 0;
        i_rx_ready <= ({$random(seed)} % 4) != 0;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

// File: sources.f
design/dm_split_pkg.sv
design/dm_meta_ram.sv
design/dm_req_decode.sv
design/dm_req_chunker.sv
design/dm_cpl_fixup.sv
design/dm_req_splitter_top.sv
tb/dm_split_checker.sv
tb/tb_dm_req_splitter.sv

// File: Bender.yml
package:
  name: dm_req_splitter

sources:
  - design/dm_split_pkg.sv
  - design/dm_meta_ram.sv
  - design/dm_req_decode.sv
  - design/dm_req_chunker.sv
  - design/dm_cpl_fixup.sv
  - design/dm_req_splitter_top.sv
  - target: test
    files:
      - tb/dm_split_checker.sv
      - tb/tb_dm_req_splitter.sv
